// ==== fpga_glue.f ====
fpga_glue_pkg.sv
key_debounce.sv
reset_req_pulse.sv
heartbeat_blinker.sv
fpga_glue_top.sv
fpga_glue_tb.sv

// ==== fpga_glue_pkg.sv ====
// fpga glue package: shared widths, vector types, pulse fsm states and default timing constants
`default_nettype none

package fpga_glue_pkg;

  // ======================================================================
  // widths
  // ======================================================================
  localparam int key_bits       = 2;   // two push keys
  localparam int sw_bits        = 4;   // slide switches
  localparam int led_pio_bits   = 7;   // leds 7..1 from the processor
  localparam int led_bits       = 8;   // all board leds
  localparam int reset_req_bits = 3;   // cold, warm, debug
  localparam int stm_bits       = 28;  // trace hw-event word

  localparam int debounce_cnt_bits  = 16;  // enough for 50000
  localparam int pulse_cnt_bits     = 6;   // enough for 32
  localparam int heartbeat_cnt_bits = 26;  // enough for 25e6

  // ======================================================================
  // types
  // ======================================================================
  typedef logic [key_bits-1:0]       key_t;         // active low, 1 = released
  typedef logic [sw_bits-1:0]        sw_t;
  typedef logic [led_pio_bits-1:0]   led_pio_t;
  typedef logic [led_bits-1:0]       led_t;
  typedef logic [reset_req_bits-1:0] reset_req_t;   // bit 0 cold, 1 warm, 2 debug
  typedef logic [stm_bits-1:0]       stm_events_t;

  typedef logic [debounce_cnt_bits-1:0]  debounce_count_t;
  typedef logic [pulse_cnt_bits-1:0]     pulse_count_t;
  typedef logic [heartbeat_cnt_bits-1:0] heartbeat_count_t;

  // reset request pulse generator states
  typedef enum logic
  {
    pulse_idle = 1'b0,
    pulse_busy = 1'b1
  } pulse_state_t;

  // ======================================================================
  // defaults, all at 50 MHz
  // ======================================================================
  localparam int debounce_cycles_default = 50000;     // 1 ms
  localparam int heartbeat_half_default  = 25000000;  // 0.5 s per half period

  // reset request pulse lengths, in clock cycles
  localparam int cold_pulse_cycles  = 6;
  localparam int warm_pulse_cycles  = 2;
  localparam int debug_pulse_cycles = 32;

endpackage

`default_nettype wire

// ==== fpga_glue_tb.sv ====
// testbench for the fpga glue top with random keys, reset requests and leds against a cycle model
`timescale 1ns/1ps
`default_nettype none

module fpga_glue_tb
  import fpga_glue_pkg::*;
();

  // ======================================================================
  // setup
  // ======================================================================
  localparam int debounce_cycles = 20;
  localparam int heartbeat_half  = 50;
  localparam int clk_period      = 8;   // ns
  localparam int reset_cycles    = 8;

  localparam int key_segments = 60;
  localparam int glitch_max   = debounce_cycles - 1;   // never long enough to pass
  localparam int hold_min     = debounce_cycles + 5;
  localparam int hold_max     = debounce_cycles + 20;
  localparam int seg_max      = glitch_max + hold_max;  // worst case per key segment
  localparam int req_cycles   = 400;
  localparam int hb_cycles    = 6 * heartbeat_half;
  localparam int watchdog_cycles = reset_cycles + key_segments * seg_max + req_cycles
                                   + 2 * debug_pulse_cycles + hb_cycles + 1000;

  logic        fpga_clk_50 = 1'b0;
  logic        hps_fpga_reset_n;
  key_t        key;
  sw_t         sw;
  led_pio_t    led_pio;
  reset_req_t  hps_reset_req;
  led_t        led;
  key_t        button_pio;
  stm_events_t stm_hw_events;
  logic        hps_cold_reset_req_n;
  logic        hps_warm_reset_req_n;
  logic        hps_debug_reset_req_n;

  integer seed = 32'h4af3_d70f;

  // model state is updated on the rising edge and read on the falling edge
  key_t       model_button;
  key_t       key_smp1;          // key as sampled one edge ago
  key_t       key_smp2;          // two edges ago as the counter sees it
  int         key_run [key_bits];
  reset_req_t req_smp1;
  reset_req_t req_smp2;
  reset_req_t req_smp3;          // one edge older than req_smp2
  reset_req_t model_req_n;
  int         pulse_left [reset_req_bits];   // low cycles still owed
  logic       model_hb;
  int         hb_count;
  int         key_changes    = 0;
  int         pulses_started = 0;
  int         edges_ignored  = 0;

  fpga_glue_top #(
    .debounce_cycles (debounce_cycles),
    .heartbeat_half  (heartbeat_half)
  ) dut_i (
    .fpga_clk_50           (fpga_clk_50),
    .hps_fpga_reset_n      (hps_fpga_reset_n),
    .key                   (key),
    .sw                    (sw),
    .led_pio               (led_pio),
    .hps_reset_req         (hps_reset_req),
    .led                   (led),
    .button_pio            (button_pio),
    .stm_hw_events         (stm_hw_events),
    .hps_cold_reset_req_n  (hps_cold_reset_req_n),
    .hps_warm_reset_req_n  (hps_warm_reset_req_n),
    .hps_debug_reset_req_n (hps_debug_reset_req_n)
  );

  initial
  begin
    forever #(clk_period / 2) fpga_clk_50 = ~fpga_clk_50;
  end

  // ======================================================================
  // reference model
  // ======================================================================
  function automatic int pulse_length(input int ch);
    case (ch)
      0:       return cold_pulse_cycles;
      1:       return warm_pulse_cycles;
      default: return debug_pulse_cycles;
    endcase
  endfunction

  always @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin : model_update
    logic rise;
    logic busy;
    if (!hps_fpga_reset_n)
    begin
      key_smp1     = '1;   // released
      key_smp2     = '1;
      model_button = '1;
      req_smp1     = '0;
      req_smp2     = '0;
      req_smp3     = '0;
      model_req_n  = '1;
      model_hb     = 1'b0;
      hb_count     = 0;
      for (int i = 0; i < key_bits; i++)
        key_run[i] = 0;
      for (int ch = 0; ch < reset_req_bits; ch++)
        pulse_left[ch] = 0;
    end
    else
    begin
      // a key flips once it disagreed on debounce_cycles+1 edges in a row
      for (int i = 0; i < key_bits; i++)
      begin
        key_run[i] = (key_smp2[i] != model_button[i]) ? key_run[i] + 1 : 0;
        if (key_run[i] > debounce_cycles)
        begin
          model_button[i] = key_smp2[i];
          key_run[i]      = 0;
          key_changes++;
        end
      end
      // rise seen two edges after sampling and output low one edge later
      for (int ch = 0; ch < reset_req_bits; ch++)
      begin
        rise            = req_smp2[ch] & ~req_smp3[ch];
        busy            = (pulse_left[ch] != 0);
        model_req_n[ch] = !busy;
        if (busy)
        begin
          pulse_left[ch]--;
          if (rise)
            edges_ignored++;   // dropped while the pulse runs
        end
        else if (rise)
        begin
          pulse_left[ch] = pulse_length(ch);
          pulses_started++;
        end
      end
      hb_count++;
      if (hb_count == heartbeat_half)
      begin
        model_hb = ~model_hb;
        hb_count = 0;
      end
      key_smp2 = key_smp1;   // sample pipeline
      key_smp1 = key;
      req_smp3 = req_smp2;
      req_smp2 = req_smp1;
      req_smp1 = hps_reset_req;
    end
  end

  // ======================================================================
  // checking
  // ======================================================================
  task automatic stop_run(input string reason);
    $display("Checks failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
      stop_run("value mismatch");
    end
  endtask

  task automatic compare_outputs();
    led_t        exp_led;
    stm_events_t exp_stm;
    exp_led = {led_pio, model_hb};
    exp_stm = {15'd0, sw, led_pio, model_button};   // zero pad on top
    check_value("button_pio", 32'(button_pio), 32'(model_button));
    check_value("hps_cold_reset_req_n", 32'(hps_cold_reset_req_n), 32'(model_req_n[0]));
    check_value("hps_warm_reset_req_n", 32'(hps_warm_reset_req_n), 32'(model_req_n[1]));
    check_value("hps_debug_reset_req_n", 32'(hps_debug_reset_req_n), 32'(model_req_n[2]));
    check_value("led", 32'(led), 32'(exp_led));
    check_value("stm_hw_events", 32'(stm_hw_events), 32'(exp_stm));
  endtask

  // check on the falling edge and then drive new random sw and led_pio
  task automatic next_cycle();
    logic [31:0] rnd;
    @(negedge fpga_clk_50);
    compare_outputs();
    rnd     = $random(seed);
    sw      = rnd[3:0];
    led_pio = rnd[10:4];
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================
  task automatic run_key_phase();
    key_t        held;
    key_t        mask;
    logic [31:0] rnd;
    int          len;
    held = 2'b11;
    for (int seg = 0; seg < key_segments; seg++)
    begin
      rnd = $random(seed);
      if (rnd[0])
      begin
        mask = (rnd[2:1] == 2'b00) ? 2'b01 : rnd[2:1];   // at least one key moves
        len  = 1 + int'(rnd[7:3]) % glitch_max;
        key  = held ^ mask;
        repeat (len) next_cycle();
        key = held;   // bounce back
        repeat (4) next_cycle();
      end
      else
      begin
        held = rnd[2:1];
        len  = hold_min + int'(rnd[7:3]) % (hold_max - hold_min + 1);
        key  = held;
        repeat (len) next_cycle();
      end
    end
  endtask

  task automatic run_req_phase();
    logic [31:0] rnd;
    for (int c = 0; c < req_cycles; c++)
    begin
      rnd = $random(seed);
      for (int ch = 0; ch < reset_req_bits; ch++)
        if (rnd[3*ch +: 3] == 3'b000)   // one in eight
          hps_reset_req[ch] = ~hps_reset_req[ch];
      next_cycle();
    end
    hps_reset_req = '0;
    repeat (2 * debug_pulse_cycles) next_cycle();   // let the long pulse drain
  endtask

  initial
  begin
    hps_fpga_reset_n = 1'b0;
    key              = 2'b11;
    sw               = '0;
    led_pio          = '0;
    hps_reset_req    = '0;
    repeat (reset_cycles) @(negedge fpga_clk_50);
    hps_fpga_reset_n = 1'b1;

    // state right after reset
    check_value("button_pio", 32'(button_pio), 32'h3);
    check_value("hps_cold_reset_req_n", 32'(hps_cold_reset_req_n), 32'h1);
    check_value("hps_warm_reset_req_n", 32'(hps_warm_reset_req_n), 32'h1);
    check_value("hps_debug_reset_req_n", 32'(hps_debug_reset_req_n), 32'h1);
    check_value("led[0]", 32'(led[0]), 32'h0);

    run_key_phase();
    run_req_phase();
    repeat (hb_cycles) next_cycle();

    if (key_changes == 0 || pulses_started == 0 || edges_ignored == 0)
    begin
      $display("stimulus missed key holds, reset pulses or edges during a running pulse");
      stop_run("coverage");
    end
    else
    begin
      $display("All checks passed");
      $finish;
    end
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge fpga_clk_50);
    $display("timeout: the test phases ran past %0d clock cycles", watchdog_cycles);
    stop_run("timeout");
  end

endmodule

`default_nettype wire

// ==== fpga_glue_top.sv ====
// fpga glue top: key debounce, reset request pulses, heartbeat led, led map and trace word
`timescale 1ns/1ps
`default_nettype none

module fpga_glue_top
  import fpga_glue_pkg::*;
#(
  parameter int debounce_cycles = debounce_cycles_default,
  parameter int heartbeat_half  = heartbeat_half_default
)
(
  input  wire logic       fpga_clk_50,
  input  wire logic       hps_fpga_reset_n,
  input  wire key_t       key,             // push keys, active low
  input  wire sw_t        sw,              // slide switches
  input  wire led_pio_t   led_pio,         // led levels from the processor
  input  wire reset_req_t hps_reset_req,   // cold, warm, debug request levels
  output led_t            led,
  output key_t            button_pio,      // debounced keys to the processor
  output stm_events_t     stm_hw_events,
  output logic            hps_cold_reset_req_n,
  output logic            hps_warm_reset_req_n,
  output logic            hps_debug_reset_req_n
);

  logic heartbeat;   // led 0 drive

  // ======================================================================
  // push keys
  // ======================================================================
  key_debounce #(
    .debounce_cycles (debounce_cycles)
  ) debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_clean        (button_pio)
  );

  // ======================================================================
  // reset request pulses
  // ======================================================================
  reset_req_pulse #(
    .pulse_cycles (cold_pulse_cycles)
  ) cold_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[0]),   // cold
    .reset_req_n      (hps_cold_reset_req_n)
  );

  reset_req_pulse #(
    .pulse_cycles (warm_pulse_cycles)
  ) warm_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[1]),   // warm
    .reset_req_n      (hps_warm_reset_req_n)
  );

  reset_req_pulse #(
    .pulse_cycles (debug_pulse_cycles)
  ) debug_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[2]),   // debug
    .reset_req_n      (hps_debug_reset_req_n)
  );

  // ======================================================================
  // heartbeat
  // ======================================================================
  heartbeat_blinker #(
    .half_period (heartbeat_half)
  ) heartbeat_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .heartbeat        (heartbeat)
  );

  // ======================================================================
  // led bus and trace word
  // ======================================================================
  assign led = {led_pio, heartbeat};   // processor owns 7..1

  // zero pad, then switches, leds and debounced keys at the bottom
  assign stm_hw_events = {{(stm_bits - sw_bits - led_pio_bits - key_bits){1'b0}},
                          sw, led_pio, button_pio};

endmodule

`default_nettype wire

// ==== heartbeat_blinker.sv ====
// heartbeat blinker: free-running divider that toggles an led every half period
`timescale 1ns/1ps
`default_nettype none

module heartbeat_blinker
  import fpga_glue_pkg::*;
#(
  parameter int half_period = heartbeat_half_default   // cycles per led level
)
(
  input  wire logic fpga_clk_50,
  input  wire logic hps_fpga_reset_n,
  output logic      heartbeat    // led drive, 1 = on
);

  // last count before the wrap
  localparam heartbeat_count_t cnt_wrap = heartbeat_count_t'(half_period - 1);

  heartbeat_count_t cnt;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt       <= '0;
      heartbeat <= 1'b0;   // starts dark
    end
    else if (cnt == cnt_wrap)
    begin
      cnt       <= '0;
      heartbeat <= ~heartbeat;   // full blink is two wraps
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== key_debounce.sv ====
// key debouncer: two-flop synchronizer plus per-bit stability counter for the active-low keys
`timescale 1ns/1ps
`default_nettype none

module key_debounce
  import fpga_glue_pkg::*;
#(
  parameter int debounce_cycles = debounce_cycles_default
)
(
  input  wire logic fpga_clk_50,
  input  wire logic hps_fpga_reset_n,
  input  wire key_t key_raw,      // straight from the pins
  output key_t      key_clean     // debounced, still active low
);

  // counter value at which a disagreement is accepted
  localparam debounce_count_t cnt_limit = debounce_count_t'(debounce_cycles);

  // ======================================================================
  // synchronizer
  // ======================================================================
  key_t key_meta;   // first stage, may go metastable
  key_t key_sync;   // second stage, safe to use

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;   // keys at rest read high
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key_raw;
      key_sync <= key_meta;
    end
  end

  // ======================================================================
  // per-bit stability counter
  // ======================================================================
  for (genvar i = 0; i < key_bits; i++)
  begin : g_bit
    debounce_count_t cnt;      // cycles of disagreement so far
    logic            clean_q;  // accepted level for this key

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        cnt     <= '0;
        clean_q <= 1'b1;   // released
      end
      else if (key_sync[i] == clean_q)
      begin
        cnt <= '0;         // any agreement restarts the wait
      end
      else if (cnt == cnt_limit)
      begin
        clean_q <= key_sync[i];   // held long enough, take it
        cnt     <= '0;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end

    assign key_clean[i] = clean_q;
  end

endmodule

`default_nettype wire

// ==== reset_req_pulse.sv ====
// reset request pulser: turns a rising edge on a request level into a fixed-length low pulse
`timescale 1ns/1ps
`default_nettype none

module reset_req_pulse
  import fpga_glue_pkg::*;
#(
  parameter int pulse_cycles = cold_pulse_cycles   // low time of the output
)
(
  input  wire logic fpga_clk_50,
  input  wire logic hps_fpga_reset_n,
  input  wire logic req,           // request level, async to the clock
  output logic      reset_req_n    // active-low request to the processor
);

  // count loaded on entry to busy, runs down to zero
  localparam pulse_count_t cnt_load = pulse_count_t'(pulse_cycles - 1);

  // ======================================================================
  // synchronizer and edge detect
  // ======================================================================
  logic req_meta;
  logic req_sync;
  logic req_last;   // previous synchronized level
  logic req_rise;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
      req_last <= 1'b0;
    end
    else
    begin
      req_meta <= req;
      req_sync <= req_meta;
      req_last <= req_sync;
    end
  end

  assign req_rise = req_sync & ~req_last;   // low to high only

  // ======================================================================
  // pulse fsm
  // ======================================================================
  pulse_state_t state;
  pulse_count_t cnt;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state <= pulse_idle;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        pulse_idle:
        begin
          if (req_rise)
          begin
            state <= pulse_busy;
            cnt   <= cnt_load;
          end
        end
        pulse_busy:
        begin
          // edges arriving here are dropped
          if (cnt == '0)
            state <= pulse_idle;
          else
            cnt <= cnt - 1'b1;
        end
        default: state <= pulse_idle;
      endcase
    end
  end

  // registered output, one cycle behind the fsm
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      reset_req_n <= 1'b1;   // inactive
    else
      reset_req_n <= (state != pulse_busy);
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the fpga glue testbench with verilator, run it, then scan the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=fpga_glue_sim
log_file=sim.log

# compile and link in one step
verilator --binary -f fpga_glue.f --top-module fpga_glue_tb \
  -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

if [ ! -x "$build_dir/$sim_bin" ]; then
  echo "simulation binary $build_dir/$sim_bin is missing"
  exit 1
fi

# run and keep the output
"./$build_dir/$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ ! -s "$log_file" ]; then
  echo "simulation log $log_file is empty"
  exit 1
fi

if grep -q "Checks failed" "$log_file"; then
  echo "simulation FAILED"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "simulation passed"
exit 0
